//--- Bender.yml
package:
  name: regFile

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/regFilePkg.sv
      - common/wbIf.sv
      - hw/loadAlign.sv
      - regBank/regBank.sv
      - hw/storeDataPath.sv
      - hw/regFile.sv

  - target: test
    include_dirs:
      - common
    files:
      - testbench/regFileChecker.sv
      - testbench/tbRegFile.sv

//--- common/regFilePkg.sv
`include "regFile_cfg.svh"

package regFilePkg;

   // write-back source select
   typedef enum logic [1:0] {
      MX_RESULT = 2'd0,
      MX_LINK   = 2'd1,
      MX_LOAD   = 2'd2,
      MX_NONE   = 2'd3
   } mxDstT;

   // store access size, taken from the low opcode bits
   typedef enum logic [1:0] {
      ACC_BYTE = 2'd0,
      ACC_HALF = 2'd1,
      ACC_WORD = 2'd2,
      ACC_RSVD = 2'd3
   } accSizeT;

   // data bus word as byte lanes or halfword lanes
   // byte 3 and half 1 sit in the most significant bits
   typedef union packed {
      logic [`DATA_W/8-1:0][7:0]   bytes;
      logic [`DATA_W/16-1:0][15:0] halves;
   } busWordT;

endpackage

//--- common/regFile_cfg.svh
`ifndef REGFILE_CFG_SVH
`define REGFILE_CFG_SVH

// bus and register width
`define DATA_W 32

// register address width, 32 entries
`define REG_AW 5

// word-aligned link address, low two bits implied zero
`define LINK_W 30

`endif

//--- common/wbIf.sv
`include "regFile_cfg.svh"

interface wbIf;
   import regFilePkg::*;

   // destination register and its source
   logic [`REG_AW-1:0] wrAddr;
   mxDstT              mxDst;

   // candidate write-back values
   logic [`DATA_W-1:0] result;
   logic [`LINK_W-1:0] pcLink;

   // aligned load word, one cycle after the cache read
   logic [`DATA_W-1:0] loadWord;

   // execute enable delayed into the write-back stage
   logic               wrEn;

   // load aligner
   modport src (
      output loadWord
   );

   // register storage
   modport bank (
      input  wrAddr,
      input  mxDst,
      input  result,
      input  pcLink,
      input  loadWord,
      output wrEn
   );

   // store operand forwarding and io peek
   modport fwd (
      input wrAddr,
      input mxDst,
      input result,
      input loadWord
   );

endinterface

//--- flist.f
+incdir+common
common/regFilePkg.sv
common/wbIf.sv
hw/loadAlign.sv
regBank/regBank.sv
hw/storeDataPath.sv
hw/regFile.sv
testbench/regFileChecker.sv
testbench/tbRegFile.sv

//--- hw/loadAlign.sv
`include "regFile_cfg.svh"

module loadAlign (
   input  logic               gclk,
   input  logic               arstN,
   input  logic [`DATA_W-1:0] cacheDataIn,
   input  logic [3:0]         byteSel,
   wbIf.src                   wb
);
   import regFilePkg::*;

   busWordT            cacheWord;
   logic [`DATA_W-1:0] aligned;

   assign cacheWord = busWordT'(cacheDataIn);

   // pick the addressed lane and zero-extend it
   always_comb begin
      aligned = '0;
      case (byteSel)
         // byte lanes, msb first
         4'h8: begin
            aligned[7:0] = cacheWord.bytes[3];
         end
         4'h4: begin
            aligned[7:0] = cacheWord.bytes[2];
         end
         4'h2: begin
            aligned[7:0] = cacheWord.bytes[1];
         end
         4'h1: begin
            aligned[7:0] = cacheWord.bytes[0];
         end
         // halfword lanes
         4'hC: begin
            aligned[15:0] = cacheWord.halves[1];
         end
         4'h3: begin
            aligned[15:0] = cacheWord.halves[0];
         end
         // full word
         4'hF: begin
            aligned = cacheWord;
         end
         // anything else loads zero
         default: begin
            aligned = '0;
         end
      endcase
   end

   always_ff @(posedge gclk or negedge arstN) begin
      if (!arstN) begin
         wb.loadWord <= '0;
      end else begin
         wb.loadWord <= aligned;
      end
   end

endmodule

//--- hw/regFile.sv
`include "regFile_cfg.svh"

module regFile (
   input  logic               gclk,
   input  logic               arstN,
   input  logic               dEn,
   input  logic               xEn,
   input  logic [5:0]         opc,
   input  logic [`REG_AW-1:0] wrAddr,
   input  logic [`REG_AW-1:0] rdAddr,
   input  logic [`REG_AW-1:0] raAddr,
   input  logic [`REG_AW-1:0] rbAddr,
   input  regFilePkg::mxDstT  mxDst,
   input  logic [`LINK_W-1:0] pcLink,
   input  logic [`DATA_W-1:0] result,
   input  logic [`DATA_W-1:0] cacheDataIn,
   input  logic [3:0]         byteSel,
   output logic [`DATA_W-1:0] regA,
   output logic [`DATA_W-1:0] regB,
   output logic [`DATA_W-1:0] ioData,
   output logic [`DATA_W-1:0] cacheDataOut
);
   import regFilePkg::*;

   accSizeT            storeSize;
   logic [`DATA_W-1:0] dstReg;

   wbIf wbBus ();

   // write-back stage inputs onto the shared bundle
   assign wbBus.wrAddr = wrAddr;
   assign wbBus.mxDst  = mxDst;
   assign wbBus.result = result;
   assign wbBus.pcLink = pcLink;

   // store size lives in the low opcode bits
   assign storeSize = accSizeT'(opc[1:0]);

   loadAlign loadAlign_inst (
      .gclk        (gclk),
      .arstN       (arstN),
      .cacheDataIn (cacheDataIn),
      .byteSel     (byteSel),
      .wb          (wbBus.src)
   );

   regBank regBank_inst (
      .gclk   (gclk),
      .arstN  (arstN),
      .dEn    (dEn),
      .xEn    (xEn),
      .raAddr (raAddr),
      .rbAddr (rbAddr),
      .rdAddr (rdAddr),
      .wb     (wbBus.bank),
      .regA   (regA),
      .regB   (regB),
      .dstReg (dstReg)
   );

   storeDataPath storeDataPath_inst (
      .rdAddr       (rdAddr),
      .raAddr       (raAddr),
      .rbAddr       (rbAddr),
      .size         (storeSize),
      .dstReg       (dstReg),
      .wb           (wbBus.fwd),
      .cacheDataOut (cacheDataOut),
      .ioData       (ioData)
   );

endmodule

//--- hw/storeDataPath.sv
`include "regFile_cfg.svh"

module storeDataPath (
   input  logic [`REG_AW-1:0]  rdAddr,
   input  logic [`REG_AW-1:0]  raAddr,
   input  logic [`REG_AW-1:0]  rbAddr,
   input  regFilePkg::accSizeT size,
   input  logic [`DATA_W-1:0]  dstReg,
   wbIf.fwd                    wb,
   output logic [`DATA_W-1:0]  cacheDataOut,
   output logic [`DATA_W-1:0]  ioData
);
   import regFilePkg::*;

   logic    dstHit;
   logic    fwdLoad;
   logic    fwdResult;
   busWordT operand;
   busWordT sized;

   // store source is being written back right now
   assign dstHit    = (wb.wrAddr == rdAddr) && (wb.wrAddr != '0);
   assign fwdLoad   = dstHit && (wb.mxDst == MX_LOAD);
   assign fwdResult = dstHit && (wb.mxDst == MX_RESULT);

   // load forward wins over result forward
   always_comb begin
      if (fwdLoad) begin
         operand = busWordT'(wb.loadWord);
      end else if (fwdResult) begin
         operand = busWordT'(wb.result);
      end else begin
         operand = busWordT'(dstReg);
      end
   end

   // replicate the operand over all lanes of the bus
   always_comb begin
      sized = '0;
      case (size)
         ACC_BYTE: begin
            sized.bytes = {(`DATA_W/8){operand.bytes[0]}};
         end
         ACC_HALF: begin
            sized.halves = {(`DATA_W/16){operand.halves[0]}};
         end
         ACC_WORD: begin
            sized = operand;
         end
         ACC_RSVD: begin
            sized = '0;
         end
      endcase
   end

   assign cacheDataOut = sized;

   // io peek, result if either operand port names the destination
   assign ioData = ((wb.wrAddr == raAddr) || (wb.wrAddr == rbAddr)) ?
                   wb.result : wb.loadWord;

endmodule

//--- regBank/regBank.sv
`include "regFile_cfg.svh"

module regBank (
   input  logic               gclk,
   input  logic               arstN,
   input  logic               dEn,
   input  logic               xEn,
   input  logic [`REG_AW-1:0] raAddr,
   input  logic [`REG_AW-1:0] rbAddr,
   input  logic [`REG_AW-1:0] rdAddr,
   wbIf.bank                  wb,
   output logic [`DATA_W-1:0] regA,
   output logic [`DATA_W-1:0] regB,
   output logic [`DATA_W-1:0] dstReg
);
   import regFilePkg::*;

   localparam int NumRegs = 2 ** `REG_AW;

   logic [`DATA_W-1:0] regs [NumRegs];
   logic [`DATA_W-1:0] wrData;
   logic [`DATA_W-1:0] regD;
   logic               doWrite;

   // execute enable lines up with the write-back stage
   always_ff @(posedge gclk or negedge arstN) begin
      if (!arstN) begin
         wb.wrEn <= 1'b0;
      end else begin
         wb.wrEn <= xEn;
      end
   end

   // write-back source
   always_comb begin
      case (wb.mxDst)
         MX_RESULT: begin
            wrData = wb.result;
         end
         MX_LINK: begin
            wrData = {wb.pcLink, {(`DATA_W - `LINK_W){1'b0}}};
         end
         MX_LOAD: begin
            wrData = wb.loadWord;
         end
         MX_NONE: begin
            wrData = '0;
         end
      endcase
   end

   // r0 stays zero, none source writes nothing
   assign doWrite = wb.wrEn && (wb.wrAddr != '0) && (wb.mxDst != MX_NONE);

   always_ff @(posedge gclk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (doWrite) begin
         regs[wb.wrAddr] <= wrData;
      end
   end

   // read ports see the contents from before this edge's write
   always_ff @(posedge gclk or negedge arstN) begin
      if (!arstN) begin
         regA <= '0;
         regB <= '0;
         regD <= '0;
      end else if (dEn) begin
         regA <= regs[raAddr];
         regB <= regs[rbAddr];
         regD <= regs[rdAddr];
      end
   end

   // store operand gets one more stage
   always_ff @(posedge gclk or negedge arstN) begin
      if (!arstN) begin
         dstReg <= '0;
      end else begin
         dstReg <= regD;
      end
   end

endmodule

//--- testbench/regFileChecker.sv
`include "regFile_cfg.svh"

module regFileChecker (
   input  logic               gclk,
   input  logic               arstN,
   input  logic               dEn,
   input  logic               xEn,
   input  logic [5:0]         opc,
   input  logic [`REG_AW-1:0] wrAddr,
   input  logic [`REG_AW-1:0] rdAddr,
   input  logic [`REG_AW-1:0] raAddr,
   input  logic [`REG_AW-1:0] rbAddr,
   input  regFilePkg::mxDstT  mxDst,
   input  logic [`LINK_W-1:0] pcLink,
   input  logic [`DATA_W-1:0] result,
   input  logic [`DATA_W-1:0] cacheDataIn,
   input  logic [3:0]         byteSel,
   input  logic [`DATA_W-1:0] regA,
   input  logic [`DATA_W-1:0] regB,
   input  logic [`DATA_W-1:0] ioData,
   input  logic [`DATA_W-1:0] cacheDataOut,
   output int                 errorCount
);
   timeunit 1ns;
   timeprecision 100ps;
   import regFilePkg::*;

   // model state
   logic [31:0] mRegs [32];
   logic [31:0] mLoad;
   logic [31:0] mA;
   logic [31:0] mB;
   logic [31:0] mD;
   logic [31:0] mDst;
   logic        mWrEn;

   string testName;
   int    testChecks;
   int    testErrors;
   int    testsOk;
   int    testsFailed;
   int    totalChecks;

   initial begin
      errorCount = 0;
      testName = "idle";
      testChecks = 0;
      testErrors = 0;
      testsOk = 0;
      testsFailed = 0;
      totalChecks = 0;
   end

   task automatic startTest(input string name);
      testName = name;
      testChecks = 0;
      testErrors = 0;
   endtask

   task automatic endTest();
      if (testErrors == 0) begin
         testsOk++;
         $display("test %s: %0d checks, no errors", testName, testChecks);
      end else begin
         testsFailed++;
         $display("test %s: %0d checks, %0d errors", testName, testChecks, testErrors);
      end
   endtask

   task automatic printSummary();
      $display("tests ok %0d, tests failed %0d, checks %0d, errors %0d",
               testsOk, testsFailed, totalChecks, errorCount);
   endtask

   task automatic checkValue(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
      testChecks++;
      totalChecks++;
      if (expected !== actual) begin
         errorCount++;
         testErrors++;
         $display("ERROR %s %s: expected %08h, actual %08h", testName, what, expected, actual);
      end
   endtask

   // zero-extended lane picked by the byte select
   function automatic logic [31:0] alignLoad(input logic [31:0] word, input logic [3:0] sel);
      busWordT bw;
      bw = word;
      case (sel)
         4'h8: return {24'h0, bw.bytes[3]};
         4'h4: return {24'h0, bw.bytes[2]};
         4'h2: return {24'h0, bw.bytes[1]};
         4'h1: return {24'h0, bw.bytes[0]};
         4'hC: return {16'h0, bw.halves[1]};
         4'h3: return {16'h0, bw.halves[0]};
         4'hF: return word;
         default: return 32'h0;
      endcase
   endfunction

   function automatic logic [31:0] sizeStore(input logic [31:0] op, input accSizeT sz);
      case (sz)
         ACC_BYTE: return {4{op[7:0]}};
         ACC_HALF: return {2{op[15:0]}};
         ACC_WORD: return op;
         default: return 32'h0;
      endcase
   endfunction

   always @(posedge gclk) begin : model
      logic        hit;
      logic [31:0] operand;
      logic [31:0] wrData;
      if (!arstN) begin
         for (int i = 0; i < 32; i++) begin
            mRegs[i] = '0;
         end
         mLoad = '0;
         mA = '0;
         mB = '0;
         mD = '0;
         mDst = '0;
         mWrEn = 1'b0;
      end else begin
         // outputs still show the state from before this edge
         checkValue("regA", mA, regA);
         checkValue("regB", mB, regB);
         checkValue("ioData", ((wrAddr == raAddr) || (wrAddr == rbAddr)) ? result : mLoad,
                    ioData);
         hit = (wrAddr == rdAddr) && (wrAddr != 0);
         if (hit && mxDst == MX_LOAD) begin
            operand = mLoad;
         end else if (hit && mxDst == MX_RESULT) begin
            operand = result;
         end else begin
            operand = mDst;
         end
         checkValue("cacheDataOut", sizeStore(operand, accSizeT'(opc[1:0])), cacheDataOut);

         // reads take the old contents, then the write lands
         mDst = mD;
         if (dEn) begin
            mA = mRegs[raAddr];
            mB = mRegs[rbAddr];
            mD = mRegs[rdAddr];
         end
         case (mxDst)
            MX_LINK: wrData = {pcLink, 2'b00};
            MX_LOAD: wrData = mLoad;
            default: wrData = result;
         endcase
         if (mWrEn && wrAddr != 0 && mxDst != MX_NONE) begin
            mRegs[wrAddr] = wrData;
         end
         mLoad = alignLoad(cacheDataIn, byteSel);
         mWrEn = xEn;
      end
   end

endmodule

//--- testbench/tbRegFile.sv
`include "regFile_cfg.svh"

module tbRegFile;
   timeunit 1ns;
   timeprecision 100ps;
   import regFilePkg::*;

   localparam int ResetCycles = 8;
   localparam int NumTests = 6;
   localparam int TestCycles = 200;
   // run limit at 1.5 times the summed test lengths
   localparam int TimeoutCycles = (NumTests * (TestCycles + 1) + ResetCycles) * 3 / 2;

   logic               gclk;
   logic               arstN;
   logic               dEn;
   logic               xEn;
   logic [5:0]         opc;
   logic [`REG_AW-1:0] wrAddr;
   logic [`REG_AW-1:0] rdAddr;
   logic [`REG_AW-1:0] raAddr;
   logic [`REG_AW-1:0] rbAddr;
   mxDstT              mxDst;
   logic [`LINK_W-1:0] pcLink;
   logic [`DATA_W-1:0] result;
   logic [`DATA_W-1:0] cacheDataIn;
   logic [3:0]         byteSel;
   logic [`DATA_W-1:0] regA;
   logic [`DATA_W-1:0] regB;
   logic [`DATA_W-1:0] ioData;
   logic [`DATA_W-1:0] cacheDataOut;
   int                 errorCount;
   int                 cycleCount;

   regFile regFile_inst (
      .gclk         (gclk),
      .arstN        (arstN),
      .dEn          (dEn),
      .xEn          (xEn),
      .opc          (opc),
      .wrAddr       (wrAddr),
      .rdAddr       (rdAddr),
      .raAddr       (raAddr),
      .rbAddr       (rbAddr),
      .mxDst        (mxDst),
      .pcLink       (pcLink),
      .result       (result),
      .cacheDataIn  (cacheDataIn),
      .byteSel      (byteSel),
      .regA         (regA),
      .regB         (regB),
      .ioData       (ioData),
      .cacheDataOut (cacheDataOut)
   );

   regFileChecker regFileChecker_inst (
      .gclk         (gclk),
      .arstN        (arstN),
      .dEn          (dEn),
      .xEn          (xEn),
      .opc          (opc),
      .wrAddr       (wrAddr),
      .rdAddr       (rdAddr),
      .raAddr       (raAddr),
      .rbAddr       (rbAddr),
      .mxDst        (mxDst),
      .pcLink       (pcLink),
      .result       (result),
      .cacheDataIn  (cacheDataIn),
      .byteSel      (byteSel),
      .regA         (regA),
      .regB         (regB),
      .ioData       (ioData),
      .cacheDataOut (cacheDataOut),
      .errorCount   (errorCount)
   );

   initial begin
      gclk = 1'b0;
      forever #4 gclk = ~gclk;
   end

   // a few hot registers so that reads, writes and forwards collide
   function automatic logic [`REG_AW-1:0] pickAddr(input bit allowZero);
      case ($urandom % 8)
         0: return 5'd1;
         1: return 5'd2;
         2: return 5'd3;
         3: return 5'd7;
         4: return allowZero ? 5'd0 : 5'd5;
         default: return 5'($urandom % 32);
      endcase
   endfunction

   function automatic logic [3:0] pickLegalSel();
      case ($urandom % 7)
         0: return 4'h8;
         1: return 4'h4;
         2: return 4'h2;
         3: return 4'h1;
         4: return 4'hC;
         5: return 4'h3;
         default: return 4'hF;
      endcase
   endfunction

   task automatic driveCycle(input int testNo);
      dEn = 1'b1;
      xEn = 1'b1;
      raAddr = pickAddr(1'b1);
      rbAddr = pickAddr(1'b1);
      rdAddr = pickAddr(1'b1);
      wrAddr = pickAddr(1'b0);
      result = $urandom;
      pcLink = $urandom;
      cacheDataIn = $urandom;
      byteSel = pickLegalSel();
      opc = $urandom;
      mxDst = MX_RESULT;
      case (testNo)
         2: begin
            mxDst = MX_LOAD;
            // some illegal selects, which load zero
            if ($urandom % 4 == 0) begin
               byteSel = $urandom;
            end
         end
         3: begin
            mxDst = MX_LINK;
         end
         4: begin
            wrAddr = pickAddr(1'b1);
            mxDst = mxDstT'($urandom % 4);
            xEn = $urandom;
            dEn = ($urandom % 3 == 0);
         end
         5: begin
            mxDst = mxDstT'($urandom % 4);
            xEn = $urandom;
         end
         6: begin
            wrAddr = $urandom;
            raAddr = $urandom;
            rbAddr = $urandom;
            rdAddr = $urandom;
            mxDst = mxDstT'($urandom % 4);
            byteSel = $urandom;
            xEn = $urandom;
            dEn = $urandom;
         end
         default: begin
         end
      endcase
   endtask

   task automatic runTest(input int testNo, input string name);
      regFileChecker_inst.startTest(name);
      repeat (TestCycles) begin
         @(negedge gclk);
         driveCycle(testNo);
      end
      @(negedge gclk);
      regFileChecker_inst.endTest();
   endtask

   initial begin
      void'($urandom(79));
      arstN = 1'b0;
      dEn = 1'b0;
      xEn = 1'b0;
      opc = '0;
      wrAddr = '0;
      rdAddr = '0;
      raAddr = '0;
      rbAddr = '0;
      mxDst = MX_NONE;
      pcLink = '0;
      result = '0;
      cacheDataIn = '0;
      byteSel = '0;
      repeat (ResetCycles) @(posedge gclk);
      @(negedge gclk);
      arstN = 1'b1;
      runTest(1, "resultWriteRead");
      runTest(2, "loadSizing");
      runTest(3, "linkWriteBack");
      runTest(4, "writeGating");
      runTest(5, "storeForward");
      runTest(6, "ioPeek");
      regFileChecker_inst.printSummary();
      if (errorCount == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   initial begin
      cycleCount = 0;
      while (cycleCount < TimeoutCycles) begin
         @(posedge gclk);
         cycleCount++;
      end
      $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display(">>> FAIL");
      $finish;
   end

endmodule
